// File: Bender.yml
package:
  name: cpu16_multicycle

sources:
  - files:
      - source/cpu_isa_pkg.sv
      - source/cpu_ctrl_pkg.sv
      - source/instr_decoder.sv
      - source/control_unit.sv
      - source/register_file.sv
      - source/alu.sv
      - source/datapath.sv
      - source/cpu_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_cpu_top.sv

// File: compile.f
+incdir+sim
source/cpu_isa_pkg.sv
source/cpu_ctrl_pkg.sv
source/instr_decoder.sv
source/control_unit.sv
source/register_file.sv
source/alu.sv
source/datapath.sv
source/cpu_top.sv
sim/tb_cpu_top.sv

// File: sim/cpu_test_program.svh
`ifndef CPU_TEST_PROGRAM_SVH
`define CPU_TEST_PROGRAM_SVH

localparam int PROG_WORDS  = 48;
localparam int STORE_COUNT = 12;

localparam cpu_isa_pkg::word_t DATA_ADDR      = 16'h00f0;   // Preset word that LW reads.
localparam cpu_isa_pkg::word_t DATA_WORD      = 16'h5a3c;
localparam cpu_isa_pkg::word_t LOAD_COPY_ADDR = 16'h0086;
localparam cpu_isa_pkg::word_t POISON_ADDR    = 16'h00ee;   // SP + 0x4e.

// Results go to r7 + offset from 0x80 and to SP + offset from 0xa0.
localparam cpu_isa_pkg::word_t PROGRAM [PROG_WORDS] = '{
    16'h6f80, 16'h68a0, 16'h6400,             // Base in r7 and SP set to 0xa0.
    16'h6935, 16'h6ac3,                       // Operands 0x35 and 0xc3.
    16'he14d, 16'hdf60,                       // ADDU into r3.
    16'he153, 16'hdf81,
    16'heb4e, 16'hdf62,                       // XOR of the sum with r2.
    16'hed8f, 16'hed2d, 16'hdfa3,
    16'h3620, 16'hd600,                       // A shift amount of 0 shifts by eight.
    16'h368b, 16'hdfc4,
    16'hec22, 16'h6001, 16'hd101,             // SLT sets T so BTEQZ falls through.
    16'hec23, 16'h6101, 16'hd202,             // SLTU clears T so BTNEZ falls through.
    16'h6001, 16'hd04e,
    16'he94a, 16'h6101, 16'hd04e,             // CMP sees different operands.
    16'he986, 16'hdf85,
    16'h6ef0, 16'h9e60, 16'hdf66,             // Load the preset word and store the copy.
    16'h2101, 16'h2901, 16'hd04e,
    16'he13b, 16'h2601, 16'hd04e, 16'h2e01,   // r6 becomes zero for the second pair.
    16'h6d2d, 16'hedc0,                       // JALR to word 45 links into r2.
    16'hd203, 16'h8000,
    16'h4efe, 16'hdfc7, 16'hea00              // Subroutine returns through JR r2.
};

// Each entry holds the address in the upper half and the data in the lower half.
localparam logic [31:0] STORES [STORE_COUNT] = '{
    32'h0080_00f8, 32'h0081_ff72, 32'h0082_003b, 32'h0083_00bd,
    32'h00a0_3500, 32'h0084_ffdc, 32'h00a1_0035, 32'h00a2_00c3,
    32'h0085_07fb, 32'h0086_5a3c, 32'h0087_fffe, 32'h00a3_002b
};

`endif

// File: sim/tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top;

    `include "cpu_test_program.svh"

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int WATCHDOG_NS  = PROG_WORDS * 5 * CLK_PERIOD * 4;

    logic               clk;
    logic               rst;
    cpu_isa_pkg::word_t mem_rdata;
    cpu_isa_pkg::word_t mem_addr;
    cpu_isa_pkg::word_t mem_wdata;
    logic               mem_we;
    logic               halted;

    cpu_isa_pkg::word_t mem [256];
    int                 store_idx = 0;   // Next entry of the expected store list.
    int                 value_errors = 0;
    int                 other_errors = 0;

    cpu_top i_cpu_top (
        .clk       (clk),
        .rst       (rst),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .halted    (halted)
    );

    assign mem_rdata = mem[mem_addr[7:0]];

    always @(posedge clk)
    begin
        if (mem_we)
            mem[mem_addr[7:0]] <= mem_wdata;
        if (rst && mem_we)
            store_idx <= store_idx + 1;
    end

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic print_error_counts();
        $display("errors: %0d mismatch, %0d other, %0d of %0d stores seen",
            value_errors, other_errors, store_idx, STORE_COUNT);
    endtask

    reset_quiet: assert property (@(posedge clk) !rst |-> !mem_we && !halted)
    else
    begin
        value_errors++;
        $display("mismatch %0t: mem_we or halted high during reset", $time);
    end

    // The single IDLE cycle puts the first fetch on the second edge after reset.
    first_fetch: assert property (@(posedge clk)
        $past(rst) && !$past(rst, 2) |-> mem_addr == 16'h0000 && !mem_we && !halted)
    else
    begin
        value_errors++;
        $display("mismatch %0t: first fetch address %h, expected 0000", $time,
            $sampled(mem_addr));
    end

    store_value: assert property (@(posedge clk) disable iff (!rst)
        mem_we && store_idx < STORE_COUNT
            |-> mem_addr == STORES[store_idx][31:16] && mem_wdata == STORES[store_idx][15:0])
    else
    begin
        value_errors++;
        $display("mismatch %0t: store %0d wrote %h at %h, expected %h at %h", $time,
            $sampled(store_idx), $sampled(mem_wdata), $sampled(mem_addr),
            STORES[$sampled(store_idx)][15:0], STORES[$sampled(store_idx)][31:16]);
    end

    store_extra: assert property (@(posedge clk) disable iff (!rst)
        mem_we |-> store_idx < STORE_COUNT)
    else
    begin
        other_errors++;
        $display("The program wrote more words than the expected store list holds.");
    end

    poison_free: assert property (@(posedge clk) disable iff (!rst)
        mem_we |-> mem_addr != POISON_ADDR)
    else
    begin
        other_errors++;
        $display("A store reached the poison address, so a branch went the wrong way.");
    end

    write_gap: assert property (@(posedge clk) disable iff (!rst)
        mem_we |-> !$past(mem_we))
    else
    begin
        other_errors++;
        $display("Bus writes happened in two consecutive cycles.");
    end

    write_spacing: assert property (@(posedge clk) disable iff (!rst)
        mem_we |-> !$past(mem_we, 2) && !$past(mem_we, 3))
    else
    begin
        other_errors++;
        $display("Two bus writes came less than four cycles apart.");
    end

    halt_complete: assert property (@(posedge clk) disable iff (!rst)
        $rose(halted) |-> store_idx == STORE_COUNT)
    else
    begin
        other_errors++;
        $display("The processor halted before all expected stores were seen.");
    end

    halt_holds: assert property (@(posedge clk) disable iff (!rst)
        halted |-> !mem_we ##1 halted)
    else
    begin
        other_errors++;
        $display("After the halt the processor wrote memory or left the halted state.");
    end

    initial
    begin
        rst = 1'b0;
        for (int i = 0; i < 256; i++)
            mem[i] = {~i[7:0], i[7:0]};
        for (int i = 0; i < PROG_WORDS; i++)
            mem[i] = PROGRAM[i];
        mem[DATA_ADDR[7:0]] = DATA_WORD;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
        wait (halted);
        repeat (8) @(posedge clk);   // Keep the halt checks running for a while.

        load_copy: assert (mem[LOAD_COPY_ADDR[7:0]] == DATA_WORD)
        else
        begin
            value_errors++;
            $display("mismatch %0t: load copy %h, expected %h", $time,
                mem[LOAD_COPY_ADDR[7:0]], DATA_WORD);
        end

        print_error_counts();
        if (value_errors + other_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns without the processor halting.", WATCHDOG_NS);
        print_error_counts();
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_isa_pkg::alu_op_e op,
    input  cpu_isa_pkg::word_t   a,
    input  cpu_isa_pkg::word_t   b,
    output cpu_isa_pkg::word_t   y
);

    logic [3:0] shamt;

    // A three-bit immediate of zero encodes a shift by eight.
    assign shamt = (b[2:0] == 3'd0) ? 4'd8 : {1'b0, b[2:0]};

    always_comb
    begin
        case (op)
            cpu_isa_pkg::ALU_PASS_A: y = a;
            cpu_isa_pkg::ALU_PASS_B: y = b;
            cpu_isa_pkg::ALU_ADD:    y = a + b;
            cpu_isa_pkg::ALU_SUB:    y = a - b;
            cpu_isa_pkg::ALU_AND:    y = a & b;
            cpu_isa_pkg::ALU_OR:     y = a | b;
            cpu_isa_pkg::ALU_NOT:    y = ~a;
            cpu_isa_pkg::ALU_XOR:    y = a ^ b;
            cpu_isa_pkg::ALU_CMP:    y = {15'd0, a != b};   // T is set when they differ.
            cpu_isa_pkg::ALU_SLLV:   y = b << a[3:0];
            cpu_isa_pkg::ALU_SRLV:   y = b >> a[3:0];
            cpu_isa_pkg::ALU_SRAV:   y = $signed(b) >>> a[3:0];
            cpu_isa_pkg::ALU_SLL:    y = a << shamt;
            cpu_isa_pkg::ALU_SRL:    y = a >> shamt;
            cpu_isa_pkg::ALU_SRA:    y = $signed(a) >>> shamt;
            cpu_isa_pkg::ALU_SLTU:   y = {15'd0, a < b};
            cpu_isa_pkg::ALU_SLT:    y = {15'd0, $signed(a) < $signed(b)};
            default:                 y = a;
        endcase
    end

endmodule

// File: source/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic                clk,
    input  logic                rst,
    input  cpu_isa_pkg::instr_e instr,
    input  cpu_isa_pkg::word_t  ir,
    output cpu_ctrl_pkg::ctrl_t ctrl,
    output logic                halted
);

    cpu_ctrl_pkg::state_e   state, next_state;
    cpu_isa_pkg::reg_addr_t rx, ry, rz;
    logic                   stores, loads, short_path, writes_reg;

    assign rx = {1'b0, ir[10:8]};
    assign ry = {1'b0, ir[7:5]};
    assign rz = {1'b0, ir[4:2]};

    assign stores = instr inside {cpu_isa_pkg::I_SW, cpu_isa_pkg::I_SW_RS, cpu_isa_pkg::I_SW_SP};
    assign loads  = instr inside {cpu_isa_pkg::I_LW, cpu_isa_pkg::I_LW_SP};

    // These end after MEM and skip write-back.
    assign short_path = stores || instr inside {cpu_isa_pkg::I_B, cpu_isa_pkg::I_BEQZ,
        cpu_isa_pkg::I_BNEZ, cpu_isa_pkg::I_BTEQZ, cpu_isa_pkg::I_BTNEZ,
        cpu_isa_pkg::I_JR, cpu_isa_pkg::I_JRRA};
    assign writes_reg = !(short_path || instr inside {cpu_isa_pkg::I_NOP, cpu_isa_pkg::I_INT,
        cpu_isa_pkg::I_HLT, cpu_isa_pkg::I_INVALID});

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            state <= cpu_ctrl_pkg::S_IDLE;
        else
            state <= next_state;
    end

    assign halted = (state == cpu_ctrl_pkg::S_HALT);

    always_comb
    begin
        ctrl = '0;

        // The IR is stable from IDEC to WB, so the decoded fields hold over those states.
        case (instr)
            cpu_isa_pkg::I_ADDSP3, cpu_isa_pkg::I_ADDSP, cpu_isa_pkg::I_LW_SP,
            cpu_isa_pkg::I_SW_RS, cpu_isa_pkg::I_SW_SP:
                ctrl.rd_a = cpu_isa_pkg::REG_SP;
            cpu_isa_pkg::I_BTEQZ, cpu_isa_pkg::I_BTNEZ: ctrl.rd_a = cpu_isa_pkg::REG_T;
            cpu_isa_pkg::I_JRRA: ctrl.rd_a = cpu_isa_pkg::REG_RA;
            cpu_isa_pkg::I_MFIH: ctrl.rd_a = cpu_isa_pkg::REG_IH;
            cpu_isa_pkg::I_NEG:  ctrl.rd_a = cpu_isa_pkg::REG_ZERO;   // 0 - ry.
            cpu_isa_pkg::I_MOVE, cpu_isa_pkg::I_MTSP, cpu_isa_pkg::I_NOT,
            cpu_isa_pkg::I_SLL, cpu_isa_pkg::I_SRA, cpu_isa_pkg::I_SRL:
                ctrl.rd_a = ry;
            default: ctrl.rd_a = rx;
        endcase

        case (instr)
            cpu_isa_pkg::I_SW_RS: ctrl.rd_b = cpu_isa_pkg::REG_RA;
            cpu_isa_pkg::I_SW_SP: ctrl.rd_b = rx;
            default:              ctrl.rd_b = ry;
        endcase

        case (instr)
            cpu_isa_pkg::I_ADDIU3: ctrl.ext = cpu_isa_pkg::EXT_SIGN4;
            cpu_isa_pkg::I_B:      ctrl.ext = cpu_isa_pkg::EXT_SIGN11;
            cpu_isa_pkg::I_LI:     ctrl.ext = cpu_isa_pkg::EXT_ZERO8;
            cpu_isa_pkg::I_LW, cpu_isa_pkg::I_SW: ctrl.ext = cpu_isa_pkg::EXT_SIGN5;
            cpu_isa_pkg::I_SLL, cpu_isa_pkg::I_SRA, cpu_isa_pkg::I_SRL:
                ctrl.ext = cpu_isa_pkg::EXT_SHAMT;
            default: ctrl.ext = cpu_isa_pkg::EXT_SIGN8;
        endcase

        case (instr)
            cpu_isa_pkg::I_JALR, cpu_isa_pkg::I_JR, cpu_isa_pkg::I_JRRA, cpu_isa_pkg::I_MFIH,
            cpu_isa_pkg::I_MFPC, cpu_isa_pkg::I_MOVE, cpu_isa_pkg::I_MTIH, cpu_isa_pkg::I_MTSP:
                ctrl.alu_op = cpu_isa_pkg::ALU_PASS_A;
            cpu_isa_pkg::I_LI:   ctrl.alu_op = cpu_isa_pkg::ALU_PASS_B;
            cpu_isa_pkg::I_NEG, cpu_isa_pkg::I_SUBU: ctrl.alu_op = cpu_isa_pkg::ALU_SUB;
            cpu_isa_pkg::I_AND:  ctrl.alu_op = cpu_isa_pkg::ALU_AND;
            cpu_isa_pkg::I_OR:   ctrl.alu_op = cpu_isa_pkg::ALU_OR;
            cpu_isa_pkg::I_NOT:  ctrl.alu_op = cpu_isa_pkg::ALU_NOT;
            cpu_isa_pkg::I_XOR:  ctrl.alu_op = cpu_isa_pkg::ALU_XOR;
            cpu_isa_pkg::I_CMP, cpu_isa_pkg::I_CMPI: ctrl.alu_op = cpu_isa_pkg::ALU_CMP;
            cpu_isa_pkg::I_SLLV: ctrl.alu_op = cpu_isa_pkg::ALU_SLLV;
            cpu_isa_pkg::I_SRLV: ctrl.alu_op = cpu_isa_pkg::ALU_SRLV;
            cpu_isa_pkg::I_SRAV: ctrl.alu_op = cpu_isa_pkg::ALU_SRAV;
            cpu_isa_pkg::I_SLL:  ctrl.alu_op = cpu_isa_pkg::ALU_SLL;
            cpu_isa_pkg::I_SRL:  ctrl.alu_op = cpu_isa_pkg::ALU_SRL;
            cpu_isa_pkg::I_SRA:  ctrl.alu_op = cpu_isa_pkg::ALU_SRA;
            cpu_isa_pkg::I_SLTU, cpu_isa_pkg::I_SLTUI: ctrl.alu_op = cpu_isa_pkg::ALU_SLTU;
            cpu_isa_pkg::I_SLT, cpu_isa_pkg::I_SLTI:   ctrl.alu_op = cpu_isa_pkg::ALU_SLT;
            default: ctrl.alu_op = cpu_isa_pkg::ALU_ADD;   // Adds, addresses and targets.
        endcase

        ctrl.sel_a_pc = instr inside {cpu_isa_pkg::I_B, cpu_isa_pkg::I_BEQZ,
            cpu_isa_pkg::I_BNEZ, cpu_isa_pkg::I_BTEQZ, cpu_isa_pkg::I_BTNEZ,
            cpu_isa_pkg::I_MFPC};
        ctrl.sel_b_imm = !(instr inside {cpu_isa_pkg::I_ADDU, cpu_isa_pkg::I_SUBU,
            cpu_isa_pkg::I_AND, cpu_isa_pkg::I_OR, cpu_isa_pkg::I_XOR, cpu_isa_pkg::I_CMP,
            cpu_isa_pkg::I_SLT, cpu_isa_pkg::I_SLTU, cpu_isa_pkg::I_NEG,
            cpu_isa_pkg::I_SLLV, cpu_isa_pkg::I_SRAV, cpu_isa_pkg::I_SRLV});
        ctrl.branch_if_nonzero = instr inside {cpu_isa_pkg::I_BNEZ, cpu_isa_pkg::I_BTNEZ};

        case (instr)
            cpu_isa_pkg::I_BEQZ, cpu_isa_pkg::I_BNEZ, cpu_isa_pkg::I_BTEQZ, cpu_isa_pkg::I_BTNEZ:
                ctrl.jump = cpu_ctrl_pkg::JMP_COND;
            cpu_isa_pkg::I_B, cpu_isa_pkg::I_JALR, cpu_isa_pkg::I_JR, cpu_isa_pkg::I_JRRA:
                ctrl.jump = cpu_ctrl_pkg::JMP_ALWAYS;
            default: ctrl.jump = cpu_ctrl_pkg::JMP_NONE;
        endcase

        case (instr)
            cpu_isa_pkg::I_ADDIU3, cpu_isa_pkg::I_LW, cpu_isa_pkg::I_SLLV,
            cpu_isa_pkg::I_SRAV, cpu_isa_pkg::I_SRLV:
                ctrl.wr_addr = ry;
            cpu_isa_pkg::I_ADDU, cpu_isa_pkg::I_SUBU: ctrl.wr_addr = rz;
            cpu_isa_pkg::I_ADDSP, cpu_isa_pkg::I_MTSP: ctrl.wr_addr = cpu_isa_pkg::REG_SP;
            cpu_isa_pkg::I_CMP, cpu_isa_pkg::I_CMPI, cpu_isa_pkg::I_SLT,
            cpu_isa_pkg::I_SLTI, cpu_isa_pkg::I_SLTU, cpu_isa_pkg::I_SLTUI:
                ctrl.wr_addr = cpu_isa_pkg::REG_T;
            cpu_isa_pkg::I_JALR: ctrl.wr_addr = cpu_isa_pkg::REG_RA;
            cpu_isa_pkg::I_MTIH: ctrl.wr_addr = cpu_isa_pkg::REG_IH;
            default: ctrl.wr_addr = rx;
        endcase

        if (loads)
            ctrl.wb_src = cpu_ctrl_pkg::WB_MEM;
        else if (instr == cpu_isa_pkg::I_JALR)
            ctrl.wb_src = cpu_ctrl_pkg::WB_NPC;   // Link address.
        else
            ctrl.wb_src = cpu_ctrl_pkg::WB_ALU;

        case (state)
            cpu_ctrl_pkg::S_IDLE: next_state = cpu_ctrl_pkg::S_IFETCH;
            cpu_ctrl_pkg::S_IFETCH:
            begin
                ctrl.load_ir  = 1'b1;
                ctrl.load_npc = 1'b1;
                next_state    = cpu_ctrl_pkg::S_IDEC;
            end
            cpu_ctrl_pkg::S_IDEC:
            begin
                ctrl.load_ab = 1'b1;
                next_state   = (instr == cpu_isa_pkg::I_HLT) ? cpu_ctrl_pkg::S_HALT
                                                             : cpu_ctrl_pkg::S_EXEC;
            end
            cpu_ctrl_pkg::S_EXEC:
            begin
                ctrl.load_alu = 1'b1;
                next_state    = cpu_ctrl_pkg::S_MEM;
            end
            cpu_ctrl_pkg::S_MEM:
            begin
                ctrl.load_pc  = 1'b1;
                ctrl.mem_we   = stores;
                ctrl.load_lmd = loads;
                next_state    = short_path ? cpu_ctrl_pkg::S_IFETCH : cpu_ctrl_pkg::S_WB;
            end
            cpu_ctrl_pkg::S_WB:
            begin
                ctrl.reg_we = writes_reg;
                next_state  = cpu_ctrl_pkg::S_IFETCH;
            end
            default: next_state = cpu_ctrl_pkg::S_HALT;   // Only reset leaves HALT.
        endcase
    end

endmodule

// File: source/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    typedef enum logic [2:0] {
        S_IDLE, S_IFETCH, S_IDEC, S_EXEC, S_MEM, S_WB, S_HALT
    } state_e;

    typedef enum logic [1:0] {JMP_NONE, JMP_COND, JMP_ALWAYS} jump_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_NPC} wb_src_e;

    typedef struct packed {
        logic                   load_npc;
        logic                   load_pc;
        logic                   load_ir;     // Also marks the fetch cycle on the memory bus.
        logic                   load_ab;     // Loads A, B and Imm together.
        logic                   load_alu;
        logic                   load_lmd;
        logic                   reg_we;
        logic                   mem_we;
        cpu_isa_pkg::reg_addr_t rd_a;
        cpu_isa_pkg::reg_addr_t rd_b;
        cpu_isa_pkg::reg_addr_t wr_addr;
        cpu_isa_pkg::ext_e      ext;
        cpu_isa_pkg::alu_op_e   alu_op;
        logic                   sel_a_pc;
        logic                   sel_b_imm;
        wb_src_e                wb_src;
        jump_e                  jump;
        logic                   branch_if_nonzero;
    } ctrl_t;

endpackage

// File: source/cpu_isa_pkg.sv
package cpu_isa_pkg;

    typedef logic [15:0] word_t;     // Data and address word.
    typedef logic [3:0]  reg_addr_t;

    // Indices 0 to 7 are the general registers.
    localparam reg_addr_t REG_RA   = 4'd2;
    localparam reg_addr_t REG_ZERO = 4'd8;    // Never written, so it always reads as zero.
    localparam reg_addr_t REG_IH   = 4'd13;
    localparam reg_addr_t REG_T    = 4'd14;
    localparam reg_addr_t REG_SP   = 4'd15;

    typedef enum logic [5:0] {
        I_ADDIU, I_ADDIU3, I_ADDSP3, I_ADDSP, I_ADDU, I_AND,
        I_B, I_BEQZ, I_BNEZ, I_BTEQZ, I_BTNEZ, I_CMP,
        I_CMPI, I_INT, I_JALR, I_JR, I_JRRA, I_LI,
        I_LW, I_LW_SP, I_MFIH, I_MFPC, I_MOVE, I_MTIH,
        I_MTSP, I_NEG, I_NOT, I_NOP, I_OR, I_SLL,
        I_SLLV, I_SLT, I_SLTI, I_SLTU, I_SLTUI, I_SRA,
        I_SRAV, I_SRL, I_SRLV, I_SUBU, I_SW, I_SW_RS,
        I_SW_SP, I_XOR, I_HLT, I_INVALID
    } instr_e;

    // Immediate shifts take their amount from B, where 0 means 8.
    // Variable shifts move B by the amount in A.
    typedef enum logic [4:0] {
        ALU_PASS_A, ALU_PASS_B, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_NOT, ALU_XOR, ALU_CMP, ALU_SLLV, ALU_SRLV, ALU_SLL,
        ALU_SRAV, ALU_SRL, ALU_SRA, ALU_SLTU, ALU_SLT
    } alu_op_e;

    typedef enum logic [2:0] {
        EXT_SIGN8,  // Low byte, sign extended.
        EXT_SIGN4,
        EXT_SIGN11,
        EXT_ZERO8,
        EXT_SIGN5,
        EXT_SHAMT   // Shift amount in bits 4 to 2.
    } ext_e;

endpackage

// File: source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic               clk,
    input  logic               rst,
    input  cpu_isa_pkg::word_t mem_rdata,
    output cpu_isa_pkg::word_t mem_addr,
    output cpu_isa_pkg::word_t mem_wdata,
    output logic               mem_we,
    output logic               halted
);

    cpu_isa_pkg::word_t  ir;
    cpu_isa_pkg::instr_e instr;
    cpu_ctrl_pkg::ctrl_t ctrl;

    instr_decoder i_instr_decoder (
        .ir    (ir),
        .instr (instr)
    );

    control_unit i_control_unit (
        .clk    (clk),
        .rst    (rst),
        .instr  (instr),
        .ir     (ir),
        .ctrl   (ctrl),
        .halted (halted)
    );

    datapath i_datapath (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .ir        (ir),
        .a_is_zero ()
    );

    assign mem_we = ctrl.mem_we;

endmodule

// File: source/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic                clk,
    input  logic                rst,
    input  cpu_ctrl_pkg::ctrl_t ctrl,
    input  cpu_isa_pkg::word_t  mem_rdata,
    output cpu_isa_pkg::word_t  mem_addr,
    output cpu_isa_pkg::word_t  mem_wdata,
    output cpu_isa_pkg::word_t  ir,
    output logic                a_is_zero
);

    cpu_isa_pkg::word_t pc, npc;
    cpu_isa_pkg::word_t a_reg, b_reg, imm, alu_out, lmd;
    cpu_isa_pkg::word_t rf_a, rf_b, imm_ext;
    cpu_isa_pkg::word_t op_a, op_b, alu_y, next_pc, wb_data;
    logic               take_jump;

    register_file i_register_file (
        .clk     (clk),
        .rst     (rst),
        .rd_a    (ctrl.rd_a),
        .rd_b    (ctrl.rd_b),
        .a       (rf_a),
        .b       (rf_b),
        .we      (ctrl.reg_we),
        .wr_addr (ctrl.wr_addr),
        .wr_data (wb_data)
    );

    alu i_alu (
        .op (ctrl.alu_op),
        .a  (op_a),
        .b  (op_b),
        .y  (alu_y)
    );

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            pc <= '0;
            ir <= '0;
        end
        else
        begin
            if (ctrl.load_pc)
                pc <= next_pc;
            if (ctrl.load_ir)
                ir <= mem_rdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.load_npc)
            npc <= pc + 16'd1;
        if (ctrl.load_ab)
        begin
            a_reg <= rf_a;
            b_reg <= rf_b;
            imm   <= imm_ext;
        end
        if (ctrl.load_alu)
            alu_out <= alu_y;
        if (ctrl.load_lmd)
            lmd <= mem_rdata;
    end

    always_comb
    begin
        case (ctrl.ext)
            cpu_isa_pkg::EXT_SIGN8:  imm_ext = {{8{ir[7]}}, ir[7:0]};
            cpu_isa_pkg::EXT_SIGN4:  imm_ext = {{12{ir[3]}}, ir[3:0]};
            cpu_isa_pkg::EXT_SIGN11: imm_ext = {{5{ir[10]}}, ir[10:0]};
            cpu_isa_pkg::EXT_ZERO8:  imm_ext = {8'd0, ir[7:0]};
            cpu_isa_pkg::EXT_SIGN5:  imm_ext = {{11{ir[4]}}, ir[4:0]};
            default:                 imm_ext = {13'd0, ir[4:2]};
        endcase
    end

    // Branch offsets and MFPC are taken relative to the following instruction.
    assign op_a = ctrl.sel_a_pc ? npc : a_reg;
    assign op_b = ctrl.sel_b_imm ? imm : b_reg;

    assign a_is_zero = (a_reg == '0);
    assign take_jump = (ctrl.jump == cpu_ctrl_pkg::JMP_ALWAYS)
                    || ((ctrl.jump == cpu_ctrl_pkg::JMP_COND)
                        && (a_is_zero != ctrl.branch_if_nonzero));
    assign next_pc = take_jump ? alu_out : npc;

    always_comb
    begin
        case (ctrl.wb_src)
            cpu_ctrl_pkg::WB_MEM: wb_data = lmd;
            cpu_ctrl_pkg::WB_NPC: wb_data = npc;
            default:              wb_data = alu_out;
        endcase
    end

    assign mem_addr  = ctrl.load_ir ? pc : alu_out;   // One port for fetch and data.
    assign mem_wdata = b_reg;

endmodule

// File: source/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  cpu_isa_pkg::word_t  ir,
    output cpu_isa_pkg::instr_e instr
);

    always_comb
    begin
        instr = cpu_isa_pkg::I_INVALID;
        case (ir[15:11])
            5'b00000: instr = cpu_isa_pkg::I_ADDSP3;
            5'b00001: instr = cpu_isa_pkg::I_NOP;
            5'b00010: instr = cpu_isa_pkg::I_B;
            5'b00100: instr = cpu_isa_pkg::I_BEQZ;
            5'b00101: instr = cpu_isa_pkg::I_BNEZ;
            5'b01000: instr = cpu_isa_pkg::I_ADDIU3;
            5'b01001: instr = cpu_isa_pkg::I_ADDIU;
            5'b01010: instr = cpu_isa_pkg::I_SLTI;
            5'b01011: instr = cpu_isa_pkg::I_SLTUI;
            5'b01101: instr = cpu_isa_pkg::I_LI;
            5'b01110: instr = cpu_isa_pkg::I_CMPI;
            5'b01111: instr = cpu_isa_pkg::I_MOVE;
            5'b10000: instr = cpu_isa_pkg::I_HLT;
            5'b10010: instr = cpu_isa_pkg::I_LW_SP;
            5'b10011: instr = cpu_isa_pkg::I_LW;
            5'b11010: instr = cpu_isa_pkg::I_SW_SP;
            5'b11011: instr = cpu_isa_pkg::I_SW;
            5'b11111: instr = cpu_isa_pkg::I_INT;
            5'b00110:
                case (ir[1:0])
                    2'b00: instr = cpu_isa_pkg::I_SLL;
                    2'b10: instr = cpu_isa_pkg::I_SRL;
                    2'b11: instr = cpu_isa_pkg::I_SRA;
                endcase
            5'b01100:
                case (ir[10:8])
                    3'b000: instr = cpu_isa_pkg::I_BTEQZ;
                    3'b001: instr = cpu_isa_pkg::I_BTNEZ;
                    3'b010: instr = cpu_isa_pkg::I_SW_RS;
                    3'b011: instr = cpu_isa_pkg::I_ADDSP;
                    3'b100: instr = cpu_isa_pkg::I_MTSP;
                endcase
            5'b11100:
                case (ir[1:0])
                    2'b01: instr = cpu_isa_pkg::I_ADDU;
                    2'b11: instr = cpu_isa_pkg::I_SUBU;
                endcase
            5'b11101:
                case (ir[4:0])
                    5'b00010: instr = cpu_isa_pkg::I_SLT;
                    5'b00011: instr = cpu_isa_pkg::I_SLTU;
                    5'b00100: instr = cpu_isa_pkg::I_SLLV;
                    5'b00110: instr = cpu_isa_pkg::I_SRLV;
                    5'b00111: instr = cpu_isa_pkg::I_SRAV;
                    5'b01010: instr = cpu_isa_pkg::I_CMP;
                    5'b01011: instr = cpu_isa_pkg::I_NEG;
                    5'b01100: instr = cpu_isa_pkg::I_AND;
                    5'b01101: instr = cpu_isa_pkg::I_OR;
                    5'b01110: instr = cpu_isa_pkg::I_XOR;
                    5'b01111: instr = cpu_isa_pkg::I_NOT;
                    5'b00000:
                        case (ir[7:5])   // Jump group.
                            3'b000: instr = cpu_isa_pkg::I_JR;
                            3'b001: instr = cpu_isa_pkg::I_JRRA;
                            3'b010: instr = cpu_isa_pkg::I_MFPC;
                            3'b110: instr = cpu_isa_pkg::I_JALR;
                        endcase
                endcase
            5'b11110:
                case (ir[7:0])
                    8'h00: instr = cpu_isa_pkg::I_MFIH;
                    8'h01: instr = cpu_isa_pkg::I_MTIH;
                endcase
        endcase
    end

endmodule

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_isa_pkg::reg_addr_t rd_a,
    input  cpu_isa_pkg::reg_addr_t rd_b,
    output cpu_isa_pkg::word_t     a,
    output cpu_isa_pkg::word_t     b,
    input  logic                   we,
    input  cpu_isa_pkg::reg_addr_t wr_addr,
    input  cpu_isa_pkg::word_t     wr_data
);

    // General registers at 0 to 7, IH, T and SP at the top.
    cpu_isa_pkg::word_t regs [16];

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
        end
        else if (we)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign a = regs[rd_a];
    assign b = regs[rd_b];

endmodule
